/* src/fc_defines.svh */
`ifndef FC_DEFINES_SVH
`define FC_DEFINES_SVH

//////////////////////////////
// Layer geometry
//////////////////////////////
`define FC_LANES          4      // Neuron lanes
`define FC_BEATS          64     // Beats per feature vector
`define FC_BYTES_PER_BEAT 8      // Byte pairs per beat

//////////////////////////////
// APB address map
//////////////////////////////
`define FC_ADDR_W    13          // APB byte address width
`define FC_FEAT_BASE 13'h0000    // Feature words
`define FC_WGT_BASE  13'h0800    // Lane stride 0x200, beat stride 8
`define FC_BIAS_BASE 13'h1000    // One word per lane
`define FC_CTRL_ADDR 13'h1010    // Bit 0 starts a run
`define FC_STAT_ADDR 13'h1014    // Bit 0 done, bit 1 busy
`define FC_RES_BASE  13'h1020    // One result word per lane

`endif

/* src/fc_data_pkg.sv */
`default_nettype none

`include "fc_defines.svh"

package fc_data_pkg;

    //////////////////////////////
    // Arithmetic widths
    //////////////////////////////
    typedef logic        [7:0]  feat_t;   // Unsigned feature byte
    typedef logic signed [7:0]  wgt_t;    // Signed weight byte

    // Eight bytes side by side, byte 0 in the low bits
    typedef logic [`FC_BYTES_PER_BEAT*8-1:0] beat_vec_t;

    typedef logic signed [19:0] psum_t;   // Sum of eight products
    typedef logic signed [25:0] acc_t;    // Sum over all beats
    typedef logic signed [25:0] bias_t;
    typedef logic signed [20:0] result_t; // Low bits of bias plus total

    // Shared feature beat, same for every lane
    typedef struct packed
    {
        beat_vec_t data;
        logic      valid;
    } fc_beat_t;

endpackage

`default_nettype wire

/* src/fc_ctrl_pkg.sv */
`default_nettype none

`include "fc_defines.svh"

package fc_ctrl_pkg;

    typedef logic [31:0] apb_data_t;

    // Host side of the APB port
    typedef struct packed
    {
        logic [`FC_ADDR_W-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        apb_data_t             pwdata;
    } apb_req_t;

    typedef enum logic [1:0] {FEAT, WGT, BIAS} region_t;

    // One 32-bit half written into a feeder memory
    typedef struct packed
    {
        logic                         we;
        region_t                      region;
        logic [$clog2(`FC_LANES)-1:0] lane;   // Weight and bias only
        logic [$clog2(`FC_BEATS)-1:0] beat;
        logic                         half;   // 1 selects bytes 4..7
        apb_data_t                    data;
    } mem_wr_t;

    typedef enum logic {FEED_IDLE, FEED_STREAM} feed_state_t;

endpackage

`default_nettype wire

/* src/fc_apb_slave.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fc_defines.svh"

module fc_apb_slave
(
    input  wire                                       clk,
    input  wire                                       rstn,
    input  wire fc_ctrl_pkg::apb_req_t                apb_req,
    output fc_ctrl_pkg::apb_data_t                    prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output fc_ctrl_pkg::mem_wr_t                      mem_wr,
    output logic                                      start,
    input  wire                                       busy,
    input  wire                                       done,
    input  wire fc_data_pkg::result_t [`FC_LANES-1:0] results
);

    localparam int LANE_W = $clog2(`FC_LANES);
    localparam int BEAT_W = $clog2(`FC_BEATS);
    localparam int SPAN   = `FC_BEATS * `FC_BYTES_PER_BEAT;  // Bytes per vector
    localparam int RES_W  = $bits(fc_data_pkg::result_t);

    logic                    setup_q;    // Previous cycle was a setup phase
    logic                    wr_acc;
    logic                    rd_acc;
    logic [`FC_ADDR_W-1:0]   feat_off;
    logic [`FC_ADDR_W-1:0]   wgt_off;
    logic [`FC_ADDR_W-1:0]   bias_off;
    logic [`FC_ADDR_W-1:0]   res_off;
    fc_data_pkg::result_t    res_sel;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            setup_q <= 1'b0;
        else
            setup_q <= apb_req.psel && !apb_req.penable;
    end

    // Access phase only counts after a setup phase
    assign wr_acc = apb_req.psel && apb_req.penable && setup_q && apb_req.pwrite;
    assign rd_acc = apb_req.psel && apb_req.penable && setup_q && !apb_req.pwrite;

    // Offsets wrap below a base, so one compare per region
    assign feat_off = apb_req.paddr - `FC_FEAT_BASE;
    assign wgt_off  = apb_req.paddr - `FC_WGT_BASE;
    assign bias_off = apb_req.paddr - `FC_BIAS_BASE;
    assign res_off  = apb_req.paddr - `FC_RES_BASE;

    //////////////////////////////
    // Write decode
    //////////////////////////////
    always_comb
    begin
        mem_wr      = '0;
        mem_wr.data = apb_req.pwdata;
        mem_wr.half = apb_req.paddr[2];                 // Same bit in every region
        mem_wr.beat = apb_req.paddr[BEAT_W+2:3];
        if (feat_off < `FC_ADDR_W'(SPAN))
        begin
            mem_wr.we     = wr_acc;
            mem_wr.region = fc_ctrl_pkg::FEAT;
        end
        else if (wgt_off < `FC_ADDR_W'(SPAN * `FC_LANES))
        begin
            mem_wr.we     = wr_acc;
            mem_wr.region = fc_ctrl_pkg::WGT;
            mem_wr.lane   = wgt_off[LANE_W+8:9];        // 0x200 per lane
        end
        else if (bias_off < `FC_ADDR_W'(4 * `FC_LANES))
        begin
            mem_wr.we     = wr_acc;
            mem_wr.region = fc_ctrl_pkg::BIAS;
            mem_wr.lane   = bias_off[LANE_W+1:2];
        end
    end

    // Feeder also ignores it, but keep the pulse clean
    assign start = wr_acc && (apb_req.paddr == `FC_CTRL_ADDR) && apb_req.pwdata[0] && !busy;

    //////////////////////////////
    // Read mux
    //////////////////////////////
    assign res_sel = results[res_off[LANE_W+1:2]];

    always_comb
    begin
        prdata = '0;                                    // Unmapped reads give 0
        if (rd_acc)
        begin
            if (apb_req.paddr == `FC_STAT_ADDR)
                prdata = {30'd0, busy, done};
            else if (res_off < `FC_ADDR_W'(4 * `FC_LANES))
                prdata = {{(32 - RES_W){res_sel[RES_W-1]}}, res_sel};  // Sign extend
        end
    end

    assign pready  = 1'b1;   // No wait states
    assign pslverr = 1'b0;

endmodule

`default_nettype wire

/* src/fc_feeder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fc_defines.svh"

module fc_feeder
(
    input  wire                                         clk,
    input  wire                                         rstn,
    input  wire fc_ctrl_pkg::mem_wr_t                   mem_wr,
    input  wire                                         start,
    output logic                                        busy,
    output fc_data_pkg::fc_beat_t                       beat,
    output fc_data_pkg::beat_vec_t [`FC_LANES-1:0]      lane_wgt,
    output fc_data_pkg::bias_t [`FC_LANES-1:0]          lane_bias
);

    localparam int BEAT_W = $clog2(`FC_BEATS);
    localparam int BIAS_W = $bits(fc_data_pkg::bias_t);

    fc_ctrl_pkg::feed_state_t  state;
    logic [BEAT_W-1:0]         cnt;                            // Beat index into the memories
    logic                      wr_ok;

    fc_data_pkg::beat_vec_t    feat_mem [`FC_BEATS];
    fc_data_pkg::beat_vec_t    wgt_mem  [`FC_LANES][`FC_BEATS];
    fc_data_pkg::bias_t        bias_q   [`FC_LANES];

    //////////////////////////////
    // Host writes, idle only
    //////////////////////////////
    assign wr_ok = mem_wr.we && (state == fc_ctrl_pkg::FEED_IDLE);

    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            case (mem_wr.region)
                fc_ctrl_pkg::FEAT: feat_mem[mem_wr.beat][{mem_wr.half, 5'd0} +: 32] <= mem_wr.data;
                fc_ctrl_pkg::WGT:  wgt_mem[mem_wr.lane][mem_wr.beat][{mem_wr.half, 5'd0} +: 32]
                                       <= mem_wr.data;
                fc_ctrl_pkg::BIAS: bias_q[mem_wr.lane] <= mem_wr.data[BIAS_W-1:0];  // Low bits
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // Stream FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= fc_ctrl_pkg::FEED_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                fc_ctrl_pkg::FEED_IDLE:
                    if (start)
                    begin
                        state <= fc_ctrl_pkg::FEED_STREAM;
                        cnt   <= '0;
                    end
                fc_ctrl_pkg::FEED_STREAM:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == BEAT_W'(`FC_BEATS - 1))   // Last beat out
                        state <= fc_ctrl_pkg::FEED_IDLE;
                end
                default: state <= fc_ctrl_pkg::FEED_IDLE;
            endcase
        end
    end

    assign busy = (state == fc_ctrl_pkg::FEED_STREAM);

    always_comb
    begin
        beat.valid = busy;             // 64 cycles right after start
        beat.data  = feat_mem[cnt];
        for (int l = 0; l < `FC_LANES; l++)
        begin
            lane_wgt[l]  = wgt_mem[l][cnt];
            lane_bias[l] = bias_q[l];
        end
    end

endmodule

`default_nettype wire

/* src/fc_mult_sum.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fc_defines.svh"

module fc_mult_sum
(
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         en,
    input  wire fc_data_pkg::beat_vec_t data,
    input  wire fc_data_pkg::beat_vec_t weight,
    output fc_data_pkg::psum_t          psum,
    output logic                        valid
);

    localparam int NB = `FC_BYTES_PER_BEAT;

    fc_data_pkg::feat_t  feat_b [NB];
    fc_data_pkg::wgt_t   wgt_b  [NB];
    fc_data_pkg::psum_t  sum_c;

    // Unsigned times signed, widened first so nothing is lost
    always_comb
    begin
        sum_c = '0;
        for (int i = 0; i < NB; i++)
        begin
            feat_b[i] = data[i*8 +: 8];
            wgt_b[i]  = weight[i*8 +: 8];
            sum_c     = sum_c + fc_data_pkg::psum_t'($signed({1'b0, feat_b[i]}))
                              * fc_data_pkg::psum_t'(wgt_b[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (en)
            psum <= sum_c;    // Held when idle
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            valid <= 1'b0;
        else
            valid <= en;      // One cycle behind the beat
    end

endmodule

`default_nettype wire

/* src/fc_acc_sum.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fc_defines.svh"

module fc_acc_sum
(
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     acc_en,
    input  wire fc_data_pkg::psum_t d,
    output fc_data_pkg::acc_t       result,
    output logic                    acc_done
);

    localparam int CNT_W = $clog2(`FC_BEATS);

    logic [CNT_W-1:0]   cnt;       // Beat sums taken so far
    fc_data_pkg::acc_t  acc;
    fc_data_pkg::acc_t  acc_nxt;
    logic               last;

    assign acc_nxt = acc + fc_data_pkg::acc_t'(d);   // Sign extended sum
    assign last    = acc_en && (cnt == CNT_W'(`FC_BEATS - 1));

    //////////////////////////////
    // Accumulate and count
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            cnt      <= '0;
            acc      <= '0;
            acc_done <= 1'b0;
        end
        else
        begin
            acc_done <= last;
            if (last)
            begin
                acc <= '0;          // Ready for the next vector
                cnt <= '0;
            end
            else if (acc_en)
            begin
                acc <= acc_nxt;
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (last)
            result <= acc_nxt;      // Total incl. the 64th sum
    end

endmodule

`default_nettype wire

/* src/fc_neuron.sv */
`timescale 1ns/10ps
`default_nettype none

module fc_neuron
(
    input  wire                         clk,
    input  wire                         rstn,
    input  wire fc_data_pkg::fc_beat_t  beat,
    input  wire fc_data_pkg::beat_vec_t weight,
    input  wire fc_data_pkg::bias_t     bias,
    output fc_data_pkg::result_t        result,
    output logic                        done
);

    localparam int RES_W = $bits(fc_data_pkg::result_t);

    fc_data_pkg::psum_t  psum;
    logic                ps_valid;
    fc_data_pkg::acc_t   acc_total;
    logic                acc_done;
    fc_data_pkg::acc_t   total;

    fc_mult_sum i_mult_sum
    (
        .clk    (clk),
        .rstn   (rstn),
        .en     (beat.valid),
        .data   (beat.data),
        .weight (weight),
        .psum   (psum),
        .valid  (ps_valid)
    );

    fc_acc_sum i_acc_sum
    (
        .clk      (clk),
        .rstn     (rstn),
        .acc_en   (ps_valid),
        .d        (psum),
        .result   (acc_total),
        .acc_done (acc_done)
    );

    // Wraps, only the low bits survive anyway
    assign total = acc_total + bias;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            result <= '0;
            done   <= 1'b0;
        end
        else
        begin
            done <= acc_done;                       // One cycle for the bias add
            if (acc_done)
                result <= total[RES_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/fc_collector.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fc_defines.svh"

module fc_collector
(
    input  wire                                       clk,
    input  wire                                       rstn,
    input  wire                                       start,
    input  wire [`FC_LANES-1:0]                       lane_done,
    input  wire fc_data_pkg::result_t [`FC_LANES-1:0] lane_result,
    output fc_data_pkg::result_t [`FC_LANES-1:0]      results,
    output logic                                      done
);

    logic [`FC_LANES-1:0] seen;        // Lanes reported this run
    logic [`FC_LANES-1:0] seen_nxt;

    assign seen_nxt = seen | lane_done;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            results <= '0;
            seen    <= '0;
            done    <= 1'b0;
        end
        else
        begin
            for (int l = 0; l < `FC_LANES; l++)
            begin
                if (lane_done[l])
                    results[l] <= lane_result[l];   // Latch on the lane pulse
            end
            if (start)
            begin
                seen <= '0;                         // New run, status back to busy
                done <= 1'b0;
            end
            else if (&seen_nxt)
            begin
                seen <= '0;
                done <= 1'b1;                       // All lanes in
            end
            else
                seen <= seen_nxt;
        end
    end

endmodule

`default_nettype wire

/* src/fc_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fc_defines.svh"

module fc_top
(
    input  wire                        clk,
    input  wire                        rstn,
    input  wire fc_ctrl_pkg::apb_req_t apb_req,
    output fc_ctrl_pkg::apb_data_t     prdata,
    output logic                       pready,
    output logic                       pslverr
);

    fc_ctrl_pkg::mem_wr_t                         mem_wr;
    logic                                         start;
    logic                                         busy;
    logic                                         done;
    fc_data_pkg::fc_beat_t                        beat;       // Shared by all lanes
    fc_data_pkg::beat_vec_t [`FC_LANES-1:0]       lane_wgt;
    fc_data_pkg::bias_t [`FC_LANES-1:0]           lane_bias;
    fc_data_pkg::result_t [`FC_LANES-1:0]         lane_result;
    logic [`FC_LANES-1:0]                         lane_done;
    fc_data_pkg::result_t [`FC_LANES-1:0]         results;

    //////////////////////////////
    // Host side
    //////////////////////////////
    fc_apb_slave i_apb_slave
    (
        .clk     (clk),
        .rstn    (rstn),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mem_wr  (mem_wr),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .results (results)
    );

    fc_feeder i_feeder
    (
        .clk       (clk),
        .rstn      (rstn),
        .mem_wr    (mem_wr),
        .start     (start),
        .busy      (busy),
        .beat      (beat),
        .lane_wgt  (lane_wgt),
        .lane_bias (lane_bias)
    );

    //////////////////////////////
    // Lanes
    //////////////////////////////
    for (genvar l = 0; l < `FC_LANES; l++)
    begin : g_lane
        fc_neuron i_neuron
        (
            .clk    (clk),
            .rstn   (rstn),
            .beat   (beat),
            .weight (lane_wgt[l]),
            .bias   (lane_bias[l]),
            .result (lane_result[l]),
            .done   (lane_done[l])
        );
    end

    fc_collector i_collector
    (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .lane_done   (lane_done),
        .lane_result (lane_result),
        .results     (results),
        .done        (done)
    );

endmodule

`default_nettype wire

/* verification/tb_fc_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fc_defines.svh"

module tb_fc_top;

    localparam int NBYTES         = `FC_BEATS * `FC_BYTES_PER_BEAT;  // Bytes per vector
    localparam int NWORDS         = NBYTES / 4;
    localparam int TIMEOUT_CYCLES = 12000;    // About 1400 cycles per run, six runs
    localparam int T_DRV          = 1;        // Drive delay after the rising edge

    logic                   clk;
    logic                   rstn;
    fc_ctrl_pkg::apb_req_t  apb_req;
    fc_ctrl_pkg::apb_data_t prdata;
    logic                   pready;
    logic                   pslverr;

    // Reference copies of the DUT memories
    logic [7:0]  feat_bytes [NBYTES];
    logic [7:0]  wgt_bytes  [`FC_LANES][NBYTES];
    logic [31:0] bias_words [`FC_LANES];

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    fc_top i_fc_top
    (
        .clk     (clk),
        .rstn    (rstn),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;      // 100 ns period
    end

    //////////////////////////////
    // Bus and check helpers
    //////////////////////////////
    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Access phase response, no wait states and no error
    task automatic check_response(input logic [`FC_ADDR_W-1:0] addr);
        checks++;
        assert (pready === 1'b1)
        else
        begin
            errors++;
            $display("Wait state seen on an access to address %h", addr);
        end
        checks++;
        assert (pslverr === 1'b0)
        else
        begin
            errors++;
            $display("Error response seen on an access to address %h", addr);
        end
    endtask

    // Called right after a drive point, leaves the bus idle
    task automatic write_word(input logic [`FC_ADDR_W-1:0] addr, input logic [31:0] data);
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        apb_req.pwrite  = 1'b1;
        apb_req.psel    = 1'b1;      // Setup phase
        apb_req.penable = 1'b0;
        @(posedge clk);
        #T_DRV;
        apb_req.penable = 1'b1;      // Access, write lands at the next edge
        #20;
        check_response(addr);
        @(posedge clk);
        #T_DRV;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic read_word(input logic [`FC_ADDR_W-1:0] addr, output logic [31:0] data);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #T_DRV;
        apb_req.penable = 1'b1;
        #20;                         // Mid access phase, prdata settled
        data = prdata;
        check_response(addr);
        @(posedge clk);
        #T_DRV;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    //////////////////////////////
    // Memory loads, model first
    //////////////////////////////
    task automatic load_feature(input int k, input logic [31:0] w);
        for (int j = 0; j < 4; j++)
            feat_bytes[k*4 + j] = w[j*8 +: 8];   // Byte 0 in the low bits
        write_word(`FC_FEAT_BASE + `FC_ADDR_W'(k * 4), w);
    endtask

    task automatic load_weight(input int lane, input int k, input logic [31:0] w);
        for (int j = 0; j < 4; j++)
            wgt_bytes[lane][k*4 + j] = w[j*8 +: 8];
        write_word(`FC_WGT_BASE + `FC_ADDR_W'(lane * 'h200 + k * 4), w);  // Beat*8 + half*4
    endtask

    task automatic load_bias(input int lane, input logic [31:0] w);
        bias_words[lane] = w;
        write_word(`FC_BIAS_BASE + `FC_ADDR_W'(lane * 4), w);
    endtask

    // Dot product plus bias, low 21 bits sign extended
    function automatic logic [31:0] model_result(input int lane);
        longint     sum;
        logic [20:0] r;
        sum = 0;
        for (int i = 0; i < NBYTES; i++)
            sum = sum + longint'(feat_bytes[i]) * longint'($signed(wgt_bytes[lane][i]));
        sum = sum + longint'($signed(bias_words[lane][25:0]));   // Bias keeps 26 bits
        r = sum[20:0];
        return {{11{r[20]}}, r};
    endfunction

    task automatic wait_for_done();
        logic [31:0] stat;
        stat = '0;
        while (!stat[0])
            read_word(`FC_STAT_ADDR, stat);      // Watchdog covers a stuck run
    endtask

    task automatic compare_results(input string name);
        logic [31:0] got;
        for (int l = 0; l < `FC_LANES; l++)
        begin
            read_word(`FC_RES_BASE + `FC_ADDR_W'(l * 4), got);
            check_word($sformatf("%s lane %0d", name, l), model_result(l), got);
        end
    endtask

    //////////////////////////////
    // Watchdog
    //////////////////////////////
    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial
    begin
        logic [31:0]        rd;
        logic [`FC_ADDR_W-1:0] addr;
        void'($urandom(54460));                // Fixed seed, once
        apb_req  = '0;
        rstn     = 1'b0;
        repeat (3) @(posedge clk);
        #T_DRV;
        rstn = 1'b1;

        // 1. Reset state
        read_word(`FC_STAT_ADDR, rd);
        check_word("reset status", 32'h0, rd);
        for (int l = 0; l < `FC_LANES; l++)
        begin
            read_word(`FC_RES_BASE + `FC_ADDR_W'(l * 4), rd);
            check_word($sformatf("reset result %0d", l), 32'h0, rd);
        end

        // 2. Random layer
        for (int k = 0; k < NWORDS; k++)
            load_feature(k, $urandom());
        for (int l = 0; l < `FC_LANES; l++)
        begin
            for (int k = 0; k < NWORDS; k++)
                load_weight(l, k, $urandom());
            load_bias(l, $urandom());
        end
        write_word(`FC_CTRL_ADDR, 32'h1);
        wait_for_done();
        compare_results("random");

        // 3. Extreme products, result wraps
        for (int k = 0; k < NWORDS; k++)
            load_feature(k, 32'hFFFF_FFFF);
        for (int l = 0; l < `FC_LANES; l++)
        begin
            for (int k = 0; k < NWORDS; k++)
                load_weight(l, k, 32'h8080_8080);   // -128 in every byte
            load_bias(l, $urandom() | 32'h0100_0000);
        end
        write_word(`FC_CTRL_ADDR, 32'h1);
        wait_for_done();
        compare_results("extreme");

        // 4. Start and writes while busy, model left alone
        write_word(`FC_CTRL_ADDR, 32'h1);
        read_word(`FC_STAT_ADDR, rd);
        check_word("busy status", 32'h2, rd);
        write_word(`FC_FEAT_BASE, $urandom());
        write_word(`FC_WGT_BASE + `FC_ADDR_W'('h200 * 2 + 20), $urandom());
        write_word(`FC_BIAS_BASE + 13'd4, $urandom());
        write_word(`FC_CTRL_ADDR, 32'h1);           // Second start, dropped
        wait_for_done();
        compare_results("busy writes");

        // 5. New biases only
        for (int l = 0; l < `FC_LANES; l++)
            load_bias(l, $urandom());
        write_word(`FC_CTRL_ADDR, 32'h1);
        read_word(`FC_STAT_ADDR, rd);
        check_word("done cleared", 32'h0, {31'd0, rd[0]});
        wait_for_done();
        compare_results("new bias");

        // 6. Unmapped reads
        read_word(`FC_CTRL_ADDR, rd);
        check_word("ctrl read", 32'h0, rd);
        read_word(13'h1018, rd);
        check_word("gap 0x1018", 32'h0, rd);
        read_word(13'h101C, rd);
        check_word("gap 0x101c", 32'h0, rd);
        for (int n = 0; n < 8; n++)
        begin
            addr = 13'h1030 + `FC_ADDR_W'(($urandom() % 'h3F4) * 4);   // Up to 0x1ffc
            read_word(addr, rd);
            check_word($sformatf("unmapped %h", addr), 32'h0, rd);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
src/fc_data_pkg.sv
src/fc_ctrl_pkg.sv
src/fc_apb_slave.sv
src/fc_feeder.sv
src/fc_mult_sum.sv
src/fc_acc_sum.sv
src/fc_neuron.sv
src/fc_collector.sv
src/fc_top.sv
verification/tb_fc_top.sv

/* run_sim.sh */
#!/bin/bash
# Build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert --top-module tb_fc_top -f flist.f -o sim_fc \
    > build.log 2>&1 \
    && ./obj_dir/sim_fc > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
